// File: bench/dcache_chk.sv
//==============================
// Controller handshake assertions
// Bound into dcache_ctrl
//==============================

`timescale 1ns/10ps

module dcache_chk
(
	input logic                   cache_clk,
	input logic                   rst_n,
	input logic                   cpu_req,
	input logic                   cpu_ack,
	input logic                   wb_req,
	input logic                   wb_ack,
	input logic                   fill_req,
	input dcache_pkg::line_addr_t fill_addr
);

	// Failed assertions so far
	int fail_count = 0;

	// One next-level request at a time
	a_one_request: assert property (@(posedge cache_clk) disable iff (!rst_n)
		!(wb_req && fill_req))
		else
		begin
			fail_count++;
			$error("wb_req and fill_req are high together");
		end

	a_wb_hold: assert property (@(posedge cache_clk) disable iff (!rst_n)
		wb_req && !wb_ack |=> wb_req)
		else
		begin
			fail_count++;
			$error("wb_req fell before wb_ack rose");
		end

	// The CPU drops cpu_req right after seeing cpu_ack
	a_ack_with_req: assert property (@(posedge cache_clk) disable iff (!rst_n)
		$rose(cpu_ack) |-> $past(cpu_req))
		else
		begin
			fail_count++;
			$error("cpu_ack rose while cpu_req was low");
		end

	a_fill_addr_stable: assert property (@(posedge cache_clk) disable iff (!rst_n)
		fill_req |=> !fill_req || $stable(fill_addr))
		else
		begin
			fail_count++;
			$error("fill_addr changed while fill_req was high");
		end

endmodule

bind dcache_ctrl dcache_chk chk_inst
(
	.cache_clk (cache_clk),
	.rst_n     (rst_n),
	.cpu_req   (cpu_req),
	.cpu_ack   (cpu_ack),
	.wb_req    (wb_req),
	.wb_ack    (wb_ack),
	.fill_req  (fill_req),
	.fill_addr (fill_addr)
);

// File: bench/dcache_tb.sv
//==============================
// Data cache testbench
// Clock, reset, random CPU accesses,
// next-level memory model, reference and checks
//==============================

`timescale 1ns/10ps

module dcache_tb;

	localparam int          N_ACCESS       = 300;
	localparam int          TIMEOUT_CYCLES = N_ACCESS * 60;
	localparam logic [31:0] SEED           = 32'h7ae5_b03e;

	logic                   cache_clk;
	logic                   rst_n;
	logic                   cpu_req;
	dcache_pkg::cpu_req_t   cpu_cmd;
	logic                   cpu_ack;
	dcache_pkg::word_t      cpu_rdata;
	logic                   wb_req;
	dcache_pkg::mem_line_t  wb_line;
	logic                   wb_ack;
	logic                   fill_req;
	dcache_pkg::line_addr_t fill_addr;
	logic                   fill_ack;
	dcache_pkg::line_t      fill_data;

	// Shadow words, next-level lines, per-line history
	dcache_pkg::word_t shadow [logic [31:0]];
	dcache_pkg::line_t mem [logic [27:0]];
	bit                written [logic [27:0]];
	bit                seen [logic [27:0]];

	// Completed reads waiting for the compare process
	logic [31:0]       rd_addr_q [$];
	dcache_pkg::word_t rd_data_q [$];

	logic [27:0] cur_line;
	int          fill_count;
	int          errors = 0;
	int          cycles = 0;
	logic [31:0] cpu_rng;
	logic [31:0] mem_rng;

	dcache_top dcache_top_inst (.*);

	initial cache_clk = 1'b0;
	always #2 cache_clk = ~cache_clk;

	//==============================
	// Helpers
	//==============================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Memory contents never written by the cache
	function automatic dcache_pkg::word_t fill_pattern(input logic [31:0] addr);
		return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
	endfunction

	// Expected read data
	function automatic dcache_pkg::word_t ref_read(input logic [31:0] addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return fill_pattern(addr);
	endfunction

	function automatic dcache_pkg::line_t mem_line(input logic [27:0] la);
		dcache_pkg::line_t line;
		if (mem.exists(la))
			return mem[la];
		for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++)
			line[w] = fill_pattern({la, 2'(w), 2'b00});
		return line;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// Inputs change half a nanosecond after the edge
	task automatic next_cycle();
		@(posedge cache_clk);
		#0.5;
	endtask

	task automatic wait_mem_delay();
		int n;
		mem_rng = xorshift32(mem_rng);
		n       = 1 + int'(mem_rng[1:0]);
		repeat (n) @(posedge cache_clk);
		#0.5;
	endtask

	// One four-phase CPU access
	task automatic cpu_access(input dcache_pkg::cpu_req_t cmd, input bit repeat_rd);
		int          lat;
		logic [27:0] la;
		la         = cmd.addr[31:4];
		cur_line   = la;
		fill_count = 0;
		cpu_cmd    = cmd;
		cpu_req    = 1'b1;
		// The first edge only samples cpu_req
		lat        = -1;
		do
		begin
			next_cycle();
			lat++;
		end
		while (!cpu_ack);
		if (cmd.we)
		begin
			shadow[cmd.addr] = cmd.wdata;
			written[la]      = 1'b1;
		end
		else
		begin
			rd_addr_q.push_back(cmd.addr);
			rd_data_q.push_back(cpu_rdata);
		end
		if (repeat_rd)
			check_value($sformatf("repeat_read_latency %h", cmd.addr), 3, lat);
		if (!seen.exists(la))
			check_value($sformatf("first_access_fills %h", la), 1, fill_count);
		else if (fill_count > 1)
			check_value($sformatf("refill_count %h", la), 1, fill_count);
		seen[la] = 1'b1;
		cpu_req  = 1'b0;
		while (cpu_ack)
			next_cycle();
	endtask

	//==============================
	// Next-level memory model
	//==============================
	initial
	begin : fill_model
		logic [27:0] la;
		forever
		begin
			next_cycle();
			if (fill_req)
			begin
				la = fill_addr;
				check_value("fill_addr", {4'h0, cur_line}, {4'h0, la});
				fill_count++;
				written[la] = 1'b0;
				wait_mem_delay();
				fill_data = mem_line(la);
				fill_ack  = 1'b1;
				while (fill_req)
					next_cycle();
				fill_ack = 1'b0;
			end
		end
	end

	// Writeback must hold a line that was stored to since its fill
	initial
	begin : wb_model
		logic [27:0] la;
		bit          dirty_line;
		int          w;
		forever
		begin
			next_cycle();
			if (wb_req)
			begin
				la = wb_line.addr;
				wait_mem_delay();
				dirty_line = written.exists(la) ? written[la] : 1'b0;
				check_value($sformatf("wb_line_written %h", la), 1, dirty_line);
				for (w = 0; w < dcache_pkg::WORDS_PER_LINE; w++)
					check_value($sformatf("wb_word %h.%0d", la, w),
						ref_read({la, 2'(w), 2'b00}), wb_line.data[w]);
				mem[la] = wb_line.data;
				wb_ack  = 1'b1;
				while (wb_req)
					next_cycle();
				wb_ack = 1'b0;
			end
		end
	end

	//==============================
	// Compare process and timeout
	//==============================
	always @(posedge cache_clk)
	begin : compare
		logic [31:0] addr;
		if (rd_addr_q.size() > 0)
		begin
			addr = rd_addr_q.pop_front();
			check_value($sformatf("read %h", addr), ref_read(addr), rd_data_q.pop_front());
		end
	end

	always @(posedge cache_clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles, %0d errors",
				TIMEOUT_CYCLES, errors);
			$display("Test FAILED");
			$finish;
		end
	end

	//==============================
	// Stimulus
	//==============================
	initial
	begin : stimulus
		dcache_pkg::cpu_req_t cmd;
		logic [31:0]          prev_addr;
		bit                   rep;
		int                   assert_fails;
		rst_n     = 1'b0;
		cpu_req   = 1'b0;
		cpu_cmd   = '0;
		wb_ack    = 1'b0;
		fill_ack  = 1'b0;
		fill_data = '0;
		cpu_rng   = SEED;
		mem_rng   = xorshift32(~SEED);
		prev_addr = '0;
		repeat (10) @(posedge cache_clk);
		#0.5;
		rst_n = 1'b1;
		check_value("reset_cpu_ack", 0, cpu_ack);
		check_value("reset_wb_req", 0, wb_req);
		check_value("reset_fill_req", 0, fill_req);
		// Four tags over four sets force conflicts
		for (int i = 0; i < N_ACCESS; i++)
		begin
			cpu_rng  = xorshift32(cpu_rng);
			rep      = (i > 0) && (cpu_rng[10:8] == 3'd0);
			cmd.we   = rep ? 1'b0 : cpu_rng[0];
			cmd.addr = rep ? prev_addr :
				{cpu_rng[3:2], 22'h15_a5f3, cpu_rng[5:4], 2'b10, cpu_rng[7:6], 2'b00};
			cpu_rng   = xorshift32(cpu_rng);
			cmd.wdata = cpu_rng;
			prev_addr = cmd.addr;
			cpu_access(cmd, rep);
		end
		repeat (2) next_cycle();
		assert_fails = dcache_top_inst.ctrl_inst.chk_inst.fail_count;
		$display("Run finished: %0d accesses, %0d errors, %0d assertion failures",
			N_ACCESS, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: flist.f
verilog/dcache_pkg.sv
verilog/way_ram.sv
verilog/status_bits.sv
verilog/victim_select.sv
verilog/way_lookup.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/dcache_chk.sv
bench/dcache_tb.sv

// File: verilog/dcache_ctrl.sv
//==============================
// Data cache controller
// Request FSM, CPU/writeback/fill handshakes
// and array write strobes
//==============================

`timescale 1ns/10ps

module dcache_ctrl
(
	input  logic                   cache_clk,
	input  logic                   rst_n,
	input  logic                   cpu_req,
	input  dcache_pkg::cpu_req_t   cpu_cmd,
	output logic                   cpu_ack,
	output dcache_pkg::word_t      cpu_rdata,
	output logic                   wb_req,
	output dcache_pkg::mem_line_t  wb_line,
	input  logic                   wb_ack,
	output logic                   fill_req,
	output dcache_pkg::line_addr_t fill_addr,
	input  logic                   fill_ack,
	input  dcache_pkg::line_t      fill_data,
	output dcache_pkg::index_t     index,
	output dcache_pkg::way_vec_t   tag_we,
	output dcache_pkg::way_vec_t   line_we,
	output dcache_pkg::tag_t       tag_wdata,
	output dcache_pkg::line_t      line_wdata,
	input  dcache_pkg::way_vec_t   hit,
	input  dcache_pkg::word_t      hit_word,
	input  dcache_pkg::line_t      hit_line,
	input  dcache_pkg::way_vec_t   victim_way,
	input  logic                   victim_dirty,
	input  dcache_pkg::tag_t       victim_tag,
	input  dcache_pkg::line_t      victim_line,
	output dcache_pkg::way_vec_t   mark_dirty,
	output dcache_pkg::way_vec_t   mark_fill
);

	dcache_pkg::ctrl_state_t state;
	dcache_pkg::cpu_req_t    req_q;
	dcache_pkg::way_vec_t    vic_way;
	dcache_pkg::tag_t        req_tag;
	dcache_pkg::word_off_t   req_off;
	logic                    write_hit;
	logic                    fill_done;

	//==============================
	// Request fields and strobes
	//==============================
	assign req_tag   = req_q.addr[dcache_pkg::ADDR_W-1:dcache_pkg::TAG_LSB];
	assign req_off   = req_q.addr[dcache_pkg::INDEX_LSB-1:dcache_pkg::WORD_OFF_LSB];
	assign index     = req_q.addr[dcache_pkg::TAG_LSB-1:dcache_pkg::INDEX_LSB];
	assign fill_addr = '{tag: req_tag, index: index};

	assign write_hit = (state == dcache_pkg::COMPARE) && req_q.we && (|hit);
	// Fill data is taken on the first edge with fill_ack high
	assign fill_done = (state == dcache_pkg::FILL) && fill_req && fill_ack;

	assign tag_we     = fill_done ? vic_way : '0;
	assign mark_fill  = tag_we;
	assign mark_dirty = write_hit ? hit : '0;
	assign line_we    = fill_done ? vic_way : mark_dirty;
	assign tag_wdata  = req_tag;

	// Refill line, or hit line merged with the store word
	always_comb
	begin
		line_wdata = hit_line;
		line_wdata[req_off] = req_q.wdata;
		if (state == dcache_pkg::FILL)
			line_wdata = fill_data;
	end

	//==============================
	// Sequencer
	//==============================
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= dcache_pkg::IDLE;
			cpu_ack  <= 1'b0;
			wb_req   <= 1'b0;
			fill_req <= 1'b0;
			vic_way  <= '0;
		end
		else
		begin
			case (state)
				dcache_pkg::IDLE:
					if (cpu_req)
						state <= dcache_pkg::LOOKUP;
				// Arrays read at this edge
				dcache_pkg::LOOKUP:
					state <= dcache_pkg::COMPARE;
				dcache_pkg::COMPARE:
				begin
					if (|hit)
						state <= dcache_pkg::ACK;
					else
					begin
						vic_way <= victim_way;
						if (victim_dirty)
						begin
							wb_req <= 1'b1;
							state  <= dcache_pkg::WB;
						end
						else
						begin
							fill_req <= 1'b1;
							state    <= dcache_pkg::FILL;
						end
					end
				end
				dcache_pkg::WB:
				begin
					if (wb_req)
					begin
						if (wb_ack)
							wb_req <= 1'b0;
					end
					else if (!wb_ack)
					begin
						fill_req <= 1'b1;
						state    <= dcache_pkg::FILL;
					end
				end
				// Back to LOOKUP so the access ends as a hit
				dcache_pkg::FILL:
				begin
					if (fill_req)
					begin
						if (fill_ack)
							fill_req <= 1'b0;
					end
					else if (!fill_ack)
						state <= dcache_pkg::LOOKUP;
				end
				dcache_pkg::ACK:
				begin
					if (!cpu_ack)
						cpu_ack <= 1'b1;
					else if (!cpu_req)
					begin
						cpu_ack <= 1'b0;
						state   <= dcache_pkg::IDLE;
					end
				end
				default:
					state <= dcache_pkg::IDLE;
			endcase
		end
	end

	// Request, read word and writeback payload
	always_ff @(posedge cache_clk)
	begin
		if (state == dcache_pkg::IDLE && cpu_req)
			req_q <= cpu_cmd;
		if (state == dcache_pkg::COMPARE)
			cpu_rdata <= hit_word;
		if (state == dcache_pkg::COMPARE && !(|hit))
			wb_line <= '{addr: '{tag: victim_tag, index: index}, data: victim_line};
	end

endmodule

// File: verilog/dcache_pkg.sv
//==============================
// Data cache shared definitions
// Widths and address layout, payload types,
// bus structs, controller states
//==============================

package dcache_pkg;

	//==============================
	// Geometry
	//==============================
	localparam int ADDR_W         = 32;
	localparam int DATA_W         = 32;
	localparam int WAYS           = 2;
	localparam int SETS           = 16;
	localparam int WORDS_PER_LINE = 4;
	localparam int BYTE_OFF_W     = $clog2(DATA_W / 8);
	localparam int WORD_OFF_W     = $clog2(WORDS_PER_LINE);
	localparam int INDEX_W        = $clog2(SETS);
	localparam int TAG_W          = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

	// Bit positions inside a byte address
	localparam int WORD_OFF_LSB = BYTE_OFF_W;
	localparam int INDEX_LSB    = BYTE_OFF_W + WORD_OFF_W;
	localparam int TAG_LSB      = INDEX_LSB + INDEX_W;

	// Replacement LFSR start value, must not be zero
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	//==============================
	// Basic types
	//==============================
	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [INDEX_W-1:0]    index_t;
	typedef logic [WORD_OFF_W-1:0] word_off_t;
	typedef word_t [WORDS_PER_LINE-1:0] line_t;
	typedef logic [WAYS-1:0]       way_vec_t;

	// CPU access, 65 bits
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		word_t             wdata;
	} cpu_req_t;

	// One line of the next level
	typedef struct packed {
		tag_t   tag;
		index_t index;
	} line_addr_t;

	// Writeback payload
	typedef struct packed {
		line_addr_t addr;
		line_t      data;
	} mem_line_t;

	typedef enum logic [2:0] {IDLE, LOOKUP, COMPARE, WB, FILL, ACK} ctrl_state_t;

endpackage

// File: verilog/dcache_top.sv
//==============================
// Data cache top level
// Controller, tag and line arrays per way,
// status bits, lookup and victim choice
//==============================

`timescale 1ns/10ps

module dcache_top
(
	input  logic                   cache_clk,
	input  logic                   rst_n,
	// CPU side
	input  logic                   cpu_req,
	input  dcache_pkg::cpu_req_t   cpu_cmd,
	output logic                   cpu_ack,
	output dcache_pkg::word_t      cpu_rdata,
	// Writeback to next level
	output logic                   wb_req,
	output dcache_pkg::mem_line_t  wb_line,
	input  logic                   wb_ack,
	// Refill from next level
	output logic                   fill_req,
	output dcache_pkg::line_addr_t fill_addr,
	input  logic                   fill_ack,
	input  dcache_pkg::line_t      fill_data
);

	dcache_pkg::index_t   index;
	dcache_pkg::way_vec_t tag_we;
	dcache_pkg::way_vec_t line_we;
	dcache_pkg::tag_t     tag_wdata;
	dcache_pkg::line_t    line_wdata;
	dcache_pkg::way_vec_t mark_dirty;
	dcache_pkg::way_vec_t mark_fill;

	dcache_pkg::tag_t  [dcache_pkg::WAYS-1:0] tags;
	dcache_pkg::line_t [dcache_pkg::WAYS-1:0] lines;

	dcache_pkg::way_vec_t valid;
	dcache_pkg::way_vec_t dirty;
	dcache_pkg::way_vec_t hit;
	dcache_pkg::word_t    hit_word;
	dcache_pkg::line_t    hit_line;
	dcache_pkg::way_vec_t victim_way;
	logic                 victim_dirty;
	dcache_pkg::tag_t     victim_tag;
	dcache_pkg::line_t    victim_line;

	dcache_ctrl ctrl_inst (.*);

	//==============================
	// Per-way arrays
	//==============================
	for (genvar w = 0; w < dcache_pkg::WAYS; w++)
	begin : g_way
		way_ram #(.entry_t(dcache_pkg::tag_t)) tag_ram_inst
		(
			.cache_clk (cache_clk),
			.index     (index),
			.we        (tag_we[w]),
			.wdata     (tag_wdata),
			.rdata     (tags[w])
		);

		way_ram #(.entry_t(dcache_pkg::line_t)) line_ram_inst
		(
			.cache_clk (cache_clk),
			.index     (index),
			.we        (line_we[w]),
			.wdata     (line_wdata),
			.rdata     (lines[w])
		);
	end

	status_bits status_inst (.*);

	victim_select victim_inst (.*);

	// CPU command is held stable for the whole access
	way_lookup lookup_inst
	(
		.tag      (cpu_cmd.addr[dcache_pkg::ADDR_W-1:dcache_pkg::TAG_LSB]),
		.word_off (cpu_cmd.addr[dcache_pkg::INDEX_LSB-1:dcache_pkg::WORD_OFF_LSB]),
		.*
	);

endmodule

// File: verilog/status_bits.sv
//==============================
// Line status
// Valid and dirty bits per set and way
//==============================

`timescale 1ns/10ps

module status_bits
(
	input  logic                 cache_clk,
	input  logic                 rst_n,
	input  dcache_pkg::index_t   index,
	input  dcache_pkg::way_vec_t mark_fill,
	input  dcache_pkg::way_vec_t mark_dirty,
	output dcache_pkg::way_vec_t valid,
	output dcache_pkg::way_vec_t dirty
);

	dcache_pkg::way_vec_t [dcache_pkg::SETS-1:0] valid_q;
	dcache_pkg::way_vec_t [dcache_pkg::SETS-1:0] dirty_q;

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else
		begin
			// Fresh line is clean
			valid_q[index] <= valid_q[index] | mark_fill;
			dirty_q[index] <= (dirty_q[index] & ~mark_fill) | mark_dirty;
		end
	end

	assign valid = valid_q[index];
	assign dirty = dirty_q[index];

endmodule

// File: verilog/victim_select.sv
//==============================
// Replacement way choice
// Invalid way first, else LFSR way
//==============================

`timescale 1ns/10ps

module victim_select
(
	input  logic                 cache_clk,
	input  logic                 rst_n,
	input  dcache_pkg::way_vec_t valid,
	output dcache_pkg::way_vec_t victim_way
);

	logic [15:0] lfsr;

	// Maximal-length taps 16, 14, 13, 11
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			lfsr <= dcache_pkg::LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	// Descending scan, lowest invalid way wins
	always_comb
	begin
		victim_way = dcache_pkg::way_vec_t'(1) << lfsr[0];
		for (int w = dcache_pkg::WAYS - 1; w >= 0; w--)
		begin
			if (!valid[w])
				victim_way = dcache_pkg::way_vec_t'(1) << w;
		end
	end

endmodule

// File: verilog/way_lookup.sv
//==============================
// Way lookup
// Tag compare, hit word and line,
// victim tag, line and dirty bit
//==============================

`timescale 1ns/10ps

module way_lookup
(
	input  dcache_pkg::tag_t                         tag,
	input  dcache_pkg::word_off_t                    word_off,
	input  dcache_pkg::tag_t  [dcache_pkg::WAYS-1:0] tags,
	input  dcache_pkg::line_t [dcache_pkg::WAYS-1:0] lines,
	input  dcache_pkg::way_vec_t                     valid,
	input  dcache_pkg::way_vec_t                     dirty,
	input  dcache_pkg::way_vec_t                     victim_way,
	output dcache_pkg::way_vec_t                     hit,
	output dcache_pkg::word_t                        hit_word,
	output dcache_pkg::line_t                        hit_line,
	output logic                                     victim_dirty,
	output dcache_pkg::tag_t                         victim_tag,
	output dcache_pkg::line_t                        victim_line
);

	//==============================
	// Hit path
	//==============================
	always_comb
	begin
		hit      = '0;
		hit_line = '0;
		for (int w = 0; w < dcache_pkg::WAYS; w++)
		begin
			hit[w] = valid[w] && (tags[w] == tag);
			// At most one way hits, so an OR acts as the mux
			if (hit[w])
				hit_line = hit_line | lines[w];
		end
	end

	assign hit_word = hit_line[word_off];

	//==============================
	// Victim path
	//==============================
	always_comb
	begin
		victim_dirty = 1'b0;
		victim_tag   = '0;
		victim_line  = '0;
		for (int w = 0; w < dcache_pkg::WAYS; w++)
		begin
			if (victim_way[w])
			begin
				victim_dirty = dirty[w];
				victim_tag   = tags[w];
				victim_line  = lines[w];
			end
		end
	end

endmodule

// File: verilog/way_ram.sv
//==============================
// Single-port synchronous array
// One entry per set, generic entry type
//==============================

`timescale 1ns/10ps

module way_ram
#(
	parameter type entry_t = logic
)
(
	input  logic               cache_clk,
	input  dcache_pkg::index_t index,
	input  logic               we,
	input  entry_t             wdata,
	output entry_t             rdata
);

	entry_t mem [dcache_pkg::SETS];

	// Read returns the old entry when written at the same edge
	always_ff @(posedge cache_clk)
	begin
		if (we)
			mem[index] <= wdata;
		rdata <= mem[index];
	end

endmodule
